// File: common/fetch_pkg.sv
package fetch_pkg;

    // address and data widths
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] inst_t;

    // tlb fields in EntryHi/EntryLo layout with 4k pages
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [3:0]  tlb_idx_t;

    // fetch exception code in Cause.ExcCode encoding
    typedef logic [4:0]  excode_t;

    localparam excode_t EXC_NONE = 5'd0;
    localparam excode_t EXC_TLBL = 5'd2;   // refill and invalid share this code
    localparam excode_t EXC_ADEL = 5'd4;   // misaligned fetch address

    // boot and exception vectors, all in kseg1
    localparam vaddr_t RESET_VEC   = 32'hbfc0_0000;
    localparam vaddr_t REFILL_VEC  = 32'hbfc0_0200;
    localparam vaddr_t GENERAL_VEC = 32'hbfc0_0380;

    localparam int     TLB_ENTRIES   = 16;
    // kseg0 and up are unmapped
    localparam vaddr_t UNMAPPED_BASE = 32'h8000_0000;

    // fetch FSM
    //   IDLE  no bus cycle, output register empty
    //   BUS   wishbone read in flight
    //   HOLD  output register holds an item for decode
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        HOLD
    } fetch_state_t;

endpackage

// File: pre_if/pre_if_stage.sv
`timescale 1ns/1ps

module pre_if_stage (
    input  logic              clk,
    input  logic              reset,
    // branch bus from decode
    input  logic              br_taken,
    input  logic              br_stall,
    input  fetch_pkg::vaddr_t br_target,
    // redirects from the exception logic
    input  logic              flush,
    input  logic              flush_refill,
    input  logic              eret,
    input  fetch_pkg::vaddr_t epc,
    // request hand-off to fetch
    input  logic              req_ready,
    output logic              req_valid,
    output fetch_pkg::vaddr_t nextpc
);

    logic              accept;
    logic              br_live;
    logic              pend_set;
    logic              pend_valid;
    fetch_pkg::vaddr_t pend_pc;
    fetch_pkg::vaddr_t pc_r;
    fetch_pkg::vaddr_t flush_vec;

    assign br_live   = br_taken && !br_stall;    // stalled branch is ignored
    assign flush_vec = flush_refill ? fetch_pkg::REFILL_VEC : fetch_pkg::GENERAL_VEC;
    assign accept    = req_valid && req_ready;

    // any redirect seen while fetch is busy has to wait
    assign pend_set  = (eret || flush || br_live) && !accept;

    assign req_valid = !reset;                   // offered from the first cycle after reset

    // next pc priority
    always_comb begin
        if (eret) begin
            nextpc = epc;
        end else if (flush) begin
            nextpc = flush_vec;
        end else if (pend_valid) begin
            nextpc = pend_pc;
        end else if (br_live) begin
            nextpc = br_target;
        end else begin
            nextpc = pc_r + 32'd4;
        end
    end

    // reset loads the boot vector as a pending redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b1;
            pend_pc    <= fetch_pkg::RESET_VEC;
        end else if (accept) begin
            pend_valid <= 1'b0;                  // redirect has been issued
        end else if (pend_set) begin
            pend_valid <= 1'b1;
            pend_pc    <= nextpc;                // already prioritized
        end
    end

    // pc of the last accepted request is the base for sequential fetch
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_r <= nextpc;
        end
    end

endmodule

// File: pre_if/itlb_lookup.sv
`timescale 1ns/1ps

module itlb_lookup (
    input  logic                clk,
    input  logic                reset,
    // lookup
    input  fetch_pkg::vaddr_t   vaddr,
    input  fetch_pkg::asid_t    cur_asid,
    // software write port
    input  logic                tlbw_en,
    input  fetch_pkg::tlb_idx_t tlbw_idx,
    input  fetch_pkg::vpn_t     tlbw_vpn,
    input  fetch_pkg::asid_t    tlbw_asid,
    input  fetch_pkg::pfn_t     tlbw_pfn,
    input  logic                tlbw_v,
    // result
    output fetch_pkg::paddr_t   paddr,
    output logic                tlb_refill,
    output logic                tlb_invalid
);

    fetch_pkg::vpn_t  tlb_vpn  [fetch_pkg::TLB_ENTRIES];
    fetch_pkg::asid_t tlb_asid [fetch_pkg::TLB_ENTRIES];
    fetch_pkg::pfn_t  tlb_pfn  [fetch_pkg::TLB_ENTRIES];
    logic             tlb_v    [fetch_pkg::TLB_ENTRIES];
    logic             tlb_present [fetch_pkg::TLB_ENTRIES];

    fetch_pkg::vpn_t  va_vpn;
    fetch_pkg::pfn_t  hit_pfn;
    logic             hit;
    logic             hit_v;
    logic             unmapped;

    assign va_vpn   = vaddr[31:12];
    assign unmapped = (vaddr >= fetch_pkg::UNMAPPED_BASE);   // kseg0/kseg1

    // present bits mark entries software has written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < fetch_pkg::TLB_ENTRIES; i++) begin
                tlb_present[i] <= 1'b0;
            end
        end else if (tlbw_en) begin
            tlb_present[tlbw_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbw_en) begin
            tlb_vpn[tlbw_idx]  <= tlbw_vpn;
            tlb_asid[tlbw_idx] <= tlbw_asid;
            tlb_pfn[tlbw_idx]  <= tlbw_pfn;
            tlb_v[tlbw_idx]    <= tlbw_v;
        end
    end

    // fully associative match on vpn and asid
    always_comb begin
        hit     = 1'b0;
        hit_v   = 1'b0;
        hit_pfn = '0;
        for (int i = 0; i < fetch_pkg::TLB_ENTRIES; i++) begin
            if (tlb_present[i] && tlb_vpn[i] == va_vpn && tlb_asid[i] == cur_asid) begin
                hit     = 1'b1;
                hit_v   = tlb_v[i];
                hit_pfn = tlb_pfn[i];
            end
        end
    end

    assign paddr       = unmapped ? {3'b000, vaddr[28:0]} : {hit_pfn, vaddr[11:0]};
    assign tlb_refill  = !unmapped && !hit;
    assign tlb_invalid = !unmapped && hit && !hit_v;

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic               clk,
    input  logic               reset,
    // request from pre-IF
    input  logic               req_valid,
    output logic               req_ready,
    input  fetch_pkg::vaddr_t  req_pc,
    input  fetch_pkg::paddr_t  req_paddr,
    input  logic               tlb_refill,
    input  logic               tlb_invalid,
    input  logic               flush,
    // wishbone classic master, read only
    output logic               wb_cyc,
    output logic               wb_stb,
    output fetch_pkg::paddr_t  wb_adr,
    input  fetch_pkg::inst_t   wb_dat_i,
    input  logic               wb_ack,
    // to decode
    output logic               fs_valid,
    output fetch_pkg::vaddr_t  fs_pc,
    output fetch_pkg::inst_t   fs_inst,
    output fetch_pkg::excode_t fs_excode,
    input  logic               ds_allowin
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::excode_t      req_excode;
    fetch_pkg::paddr_t       adr_r;
    logic                    accept;
    logic                    req_fault;
    logic                    discard;          // ack of the current cycle is stale

    // output empty, or drained/cleared this cycle, and no bus cycle open
    assign req_ready = (state == fetch_pkg::IDLE) ||
                       (state == fetch_pkg::HOLD && (ds_allowin || flush));
    assign accept    = req_valid && req_ready;

    // alignment first, then translation faults
    always_comb begin
        if (req_pc[1:0] != 2'b00) begin
            req_excode = fetch_pkg::EXC_ADEL;
        end else if (tlb_refill || tlb_invalid) begin
            req_excode = fetch_pkg::EXC_TLBL;
        end else begin
            req_excode = fetch_pkg::EXC_NONE;
        end
    end

    assign req_fault = (req_excode != fetch_pkg::EXC_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetch_pkg::IDLE;
            discard <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::IDLE: begin
                    if (accept) begin
                        state <= req_fault ? fetch_pkg::HOLD : fetch_pkg::BUS;
                    end
                end
                fetch_pkg::BUS: begin
                    if (wb_ack) begin
                        state   <= (discard || flush) ? fetch_pkg::IDLE : fetch_pkg::HOLD;
                        discard <= 1'b0;
                    end else if (flush) begin
                        discard <= 1'b1;       // let the cycle finish and drop its data
                    end
                end
                fetch_pkg::HOLD: begin
                    if (accept) begin
                        state <= req_fault ? fetch_pkg::HOLD : fetch_pkg::BUS;
                    end else if (ds_allowin || flush) begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    // the pc register serves both the bus cycle and the output item
    always_ff @(posedge clk) begin
        if (accept) begin
            fs_pc     <= req_pc;
            adr_r     <= req_paddr;
            fs_excode <= req_excode;
            fs_inst   <= '0;                        // stays zero for a fault
        end else if (state == fetch_pkg::BUS && wb_ack) begin
            fs_inst   <= wb_dat_i;
        end
    end

    assign wb_cyc   = (state == fetch_pkg::BUS);
    assign wb_stb   = (state == fetch_pkg::BUS);
    assign wb_adr   = adr_r;
    assign fs_valid = (state == fetch_pkg::HOLD);

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                clk,
    input  logic                reset,
    // branch bus
    input  logic                br_taken,
    input  logic                br_stall,
    input  fetch_pkg::vaddr_t   br_target,
    // exception redirects
    input  logic                flush,
    input  logic                flush_refill,
    input  logic                eret,
    input  fetch_pkg::vaddr_t   epc,
    input  fetch_pkg::asid_t    cur_asid,
    // tlb write port
    input  logic                tlbw_en,
    input  fetch_pkg::tlb_idx_t tlbw_idx,
    input  fetch_pkg::vpn_t     tlbw_vpn,
    input  fetch_pkg::asid_t    tlbw_asid,
    input  fetch_pkg::pfn_t     tlbw_pfn,
    input  logic                tlbw_v,
    // instruction memory
    output logic                wb_cyc,
    output logic                wb_stb,
    output fetch_pkg::paddr_t   wb_adr,
    input  fetch_pkg::inst_t    wb_dat_i,
    input  logic                wb_ack,
    // decode
    output logic                fs_valid,
    output fetch_pkg::vaddr_t   fs_pc,
    output fetch_pkg::inst_t    fs_inst,
    output fetch_pkg::excode_t  fs_excode,
    input  logic                ds_allowin
);

    fetch_pkg::vaddr_t nextpc;
    fetch_pkg::paddr_t paddr;
    logic              tlb_refill;
    logic              tlb_invalid;
    logic              req_valid;
    logic              req_ready;

    pre_if_stage i_pre_if (
        .clk          (clk),
        .reset        (reset),
        .br_taken     (br_taken),
        .br_stall     (br_stall),
        .br_target    (br_target),
        .flush        (flush),
        .flush_refill (flush_refill),
        .eret         (eret),
        .epc          (epc),
        .req_ready    (req_ready),
        .req_valid    (req_valid),
        .nextpc       (nextpc)
    );

    itlb_lookup i_itlb (
        .clk         (clk),
        .reset       (reset),
        .vaddr       (nextpc),
        .cur_asid    (cur_asid),
        .tlbw_en     (tlbw_en),
        .tlbw_idx    (tlbw_idx),
        .tlbw_vpn    (tlbw_vpn),
        .tlbw_asid   (tlbw_asid),
        .tlbw_pfn    (tlbw_pfn),
        .tlbw_v      (tlbw_v),
        .paddr       (paddr),
        .tlb_refill  (tlb_refill),
        .tlb_invalid (tlb_invalid)
    );

    fetch_stage i_fetch (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_pc      (nextpc),
        .req_paddr   (paddr),
        .tlb_refill  (tlb_refill),
        .tlb_invalid (tlb_invalid),
        .flush       (flush || eret),   // both empty the fetch stage
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .fs_valid    (fs_valid),
        .fs_pc       (fs_pc),
        .fs_inst     (fs_inst),
        .fs_excode   (fs_excode),
        .ds_allowin  (ds_allowin)
    );

endmodule

// File: test/tb_imem.sv
`timescale 1ns/1ps

module tb_imem (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  fetch_pkg::paddr_t wb_adr,
    output fetch_pkg::inst_t  wb_dat_o,
    output logic              wb_ack
);

    int unsigned wait_left;

    // each word is tagged with its own address
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::paddr_t adr);
        return adr ^ 32'h5a5a_0000;
    endfunction

    initial begin
        wb_ack    = 1'b0;
        wb_dat_o  = '0;
        wait_left = 0;
    end

    // slave outputs move 1 ns after the edge like all other stimulus
    always @(posedge clk) begin
        #1;
        if (reset) begin
            wb_ack    <= 1'b0;
            wait_left <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;                       // single cycle ack
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 0) begin
                wb_ack    <= 1'b1;
                wb_dat_o  <= word_at(wb_adr);
                wait_left <= $urandom % 4;        // wait states of the next read
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

// File: test/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    logic                clk, reset;
    logic                br_taken, br_stall, flush, flush_refill, eret;
    fetch_pkg::vaddr_t   br_target, epc;
    fetch_pkg::asid_t    cur_asid, tlbw_asid;
    logic                tlbw_en, tlbw_v;
    fetch_pkg::tlb_idx_t tlbw_idx;
    fetch_pkg::vpn_t     tlbw_vpn;
    fetch_pkg::pfn_t     tlbw_pfn;
    logic                wb_cyc, wb_stb, wb_ack;
    fetch_pkg::paddr_t   wb_adr;
    fetch_pkg::inst_t    wb_dat_i;
    logic                fs_valid, ds_allowin;
    fetch_pkg::vaddr_t   fs_pc;
    fetch_pkg::inst_t    fs_inst;
    fetch_pkg::excode_t  fs_excode;

    // TLB contents as written by the stimulus
    logic                m_present [16];
    logic                m_v [16];
    fetch_pkg::vpn_t     m_vpn [16];
    fetch_pkg::asid_t    m_asid [16];
    fetch_pkg::pfn_t     m_pfn [16];

    int                  cycles = 0;
    int                  checks = 0;
    int                  mismatches = 0;
    int                  other_errors = 0;
    int                  items = 0;
    fetch_pkg::vaddr_t   exp_pc, exp_next, held_pc;
    fetch_pkg::inst_t    exp_inst, held_inst;
    fetch_pkg::excode_t  exp_exc, held_exc;
    logic                held;

    fetch_top i_dut (.*);

    tb_imem i_imem (.clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_o(wb_dat_i), .wb_ack);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected item for a fetch at pc, and the pc of the item after it
    function automatic void expect_item(
        input  fetch_pkg::vaddr_t  pc,
        input  fetch_pkg::asid_t   asid,
        input  logic               branch,
        input  fetch_pkg::vaddr_t  target,
        output fetch_pkg::inst_t   inst,
        output fetch_pkg::excode_t exc,
        output fetch_pkg::vaddr_t  next
    );
        logic            hit;
        logic            hit_v;
        fetch_pkg::pfn_t pfn;
        hit   = 1'b0;
        hit_v = 1'b0;
        pfn   = '0;
        for (int i = 0; i < 16; i++) begin
            if (m_present[i] && m_vpn[i] == pc[31:12] && m_asid[i] == asid) begin
                hit   = 1'b1;
                hit_v = m_v[i];
                pfn   = m_pfn[i];
            end
        end
        inst = '0;
        exc  = fetch_pkg::EXC_NONE;
        if (pc[1:0] != 2'b00) begin
            exc = fetch_pkg::EXC_ADEL;
        end else if (pc[31]) begin
            inst = (pc & 32'h1fff_ffff) ^ 32'h5a5a_0000;   // kseg0/kseg1 bypass
        end else if (!hit || !hit_v) begin
            exc = fetch_pkg::EXC_TLBL;
        end else begin
            inst = ({pfn, 12'h000} | (pc & 32'h0000_0fff)) ^ 32'h5a5a_0000;
        end
        next = branch ? target : pc + 32'd4;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, items %0d, mismatches %0d, other errors %0d",
                 checks, items, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // let n items pass the decode port
    task automatic fetch_items(input int n, input logic stalls);
        int got;
        got = 0;
        while (got < n) begin
            ds_allowin = stalls ? (($urandom % 4) != 0) : 1'b1;
            if (fs_valid && ds_allowin) begin
                got++;
            end
            step();
        end
    endtask

    // branch goes out together with the item that decode takes
    task automatic branch_to(input fetch_pkg::vaddr_t target, input logic stall);
        ds_allowin = 1'b0;
        while (!fs_valid) begin
            step();
        end
        ds_allowin = 1'b1;
        br_taken   = 1'b1;
        br_stall   = stall;
        br_target  = target;
        step();
        br_taken   = 1'b0;
        br_stall   = 1'b0;
    endtask

    // flush or eret with an optional wait for an open read
    task automatic redirect(input logic to_epc, input logic refill,
                            input fetch_pkg::vaddr_t ret_pc, input logic in_bus);
        ds_allowin = 1'b1;
        while (in_bus && !wb_cyc) begin
            step();
        end
        ds_allowin   = 1'b0;
        eret         = to_epc;
        epc          = ret_pc;
        flush        = !to_epc;
        flush_refill = refill;
        step();
        eret         = 1'b0;
        flush        = 1'b0;
        flush_refill = 1'b0;
    endtask

    task automatic write_tlb(input int idx, input fetch_pkg::vpn_t vpn, input fetch_pkg::asid_t asid,
                             input fetch_pkg::pfn_t pfn, input logic v);
        tlbw_en   = 1'b1;
        tlbw_idx  = idx[3:0];
        tlbw_vpn  = vpn;
        tlbw_asid = asid;
        tlbw_pfn  = pfn;
        tlbw_v    = v;
        m_present[idx] = 1'b1;
        m_vpn[idx]     = vpn;
        m_asid[idx]    = asid;
        m_pfn[idx]     = pfn;
        m_v[idx]       = v;
        step();
        tlbw_en = 1'b0;
    endtask

    // every item at the decode port, and the output while it is stalled
    always @(negedge clk) begin
        if (reset) begin
            exp_pc = fetch_pkg::RESET_VEC;
            held   = 1'b0;
        end else begin
            if (held) begin
                check_value(fs_valid, 1'b1, "fs_valid while stalled");
                check_value(fs_pc, held_pc, "fs_pc while stalled");
                check_value(fs_inst, held_inst, "fs_inst while stalled");
                check_value(fs_excode, held_exc, "fs_excode while stalled");
            end
            check_value(wb_stb, wb_cyc, "wb_stb against wb_cyc");   // classic read, no idle strobes
            if (wb_cyc) begin
                check_value(wb_adr[1:0], 2'b00, "wb_adr alignment");
            end
            if (fs_valid && ds_allowin) begin
                expect_item(exp_pc, cur_asid, br_taken && !br_stall, br_target,
                            exp_inst, exp_exc, exp_next);
                check_value(fs_pc, exp_pc, "fs_pc");
                check_value(fs_inst, exp_inst, "fs_inst");
                check_value(fs_excode, exp_exc, "fs_excode");
                items++;
                exp_pc = exp_next;
            end
            if (eret) begin
                exp_pc = epc;
            end else if (flush) begin
                exp_pc = flush_refill ? fetch_pkg::REFILL_VEC : fetch_pkg::GENERAL_VEC;
            end
            held      = fs_valid && !ds_allowin && !flush && !eret;
            held_pc   = fs_pc;
            held_inst = fs_inst;
            held_exc  = fs_excode;
        end
    end

    // about 100 items at up to 8 cycles each stay well below 4000
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            other_errors++;
            $display("timeout: the test sequence did not end within %0d cycles", cycles);
            finish_run();
        end
    end

    initial begin
        void'($urandom(19946));
        reset = 1'b1;
        {br_taken, br_stall, flush, flush_refill, eret} = '0;
        br_target  = '0;
        epc        = '0;
        cur_asid   = 8'h05;
        {tlbw_en, tlbw_v, tlbw_idx, tlbw_vpn, tlbw_asid, tlbw_pfn} = '0;
        ds_allowin = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_present[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value(fs_valid, 1'b0, "fs_valid after reset");
        check_value(wb_cyc, 1'b0, "wb_cyc after reset");
        fetch_items(8, 1'b0);                             // boot sequence
        fetch_items(40, 1'b1);
        branch_to(32'hbfc0_1000, 1'b0);
        fetch_items(4, 1'b1);
        branch_to(32'hbfc0_2000, 1'b1);                   // stalled branch is ignored
        fetch_items(4, 1'b0);
        write_tlb(0, 20'h00400, 8'h05, 20'h01234, 1'b1);
        write_tlb(1, 20'h00401, 8'h05, 20'h00abc, 1'b0);
        write_tlb(2, 20'h00402, 8'h07, 20'h00555, 1'b1);  // other asid
        branch_to(32'h0040_0ff0, 1'b0);                   // tail of a mapped page
        fetch_items(8, 1'b1);                             // then into the invalid page
        branch_to(32'h0040_2000, 1'b0);
        fetch_items(3, 1'b0);
        redirect(1'b0, 1'b1, '0, 1'b0);
        fetch_items(6, 1'b1);
        redirect(1'b0, 1'b0, '0, 1'b1);                   // read in flight is dropped
        fetch_items(6, 1'b1);
        branch_to(32'hbfc0_0402, 1'b0);                   // misaligned
        fetch_items(3, 1'b1);
        redirect(1'b1, 1'b0, 32'h8000_0100, 1'b0);        // eret into kseg0
        fetch_items(6, 1'b1);
        redirect(1'b1, 1'b0, 32'hbfc0_3000, 1'b1);
        fetch_items(6, 1'b0);
        repeat (4) step();
        if (items < 90) begin
            other_errors++;
            $display("only %0d items reached the decode port", items);
        end
        finish_run();
    end

endmodule

// File: sources.f
common/fetch_pkg.sv
pre_if/pre_if_stage.sv
pre_if/itlb_lookup.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
test/tb_imem.sv
test/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - common/fetch_pkg.sv
      - pre_if/pre_if_stage.sv
      - pre_if/itlb_lookup.sv
      - rtl/fetch_stage.sv
      - rtl/fetch_top.sv
  - target: test
    files:
      - test/tb_imem.sv
      - test/tb_fetch_top.sv
